// ==== fetch_aligner.sv ====
`default_nettype none

`include "fetch_consts.svh"

module fetch_aligner
  import fetch_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_i,
  input  logic                     halt_i,
  input  logic                     kill_i,
  input  logic                     pc_set_i,
  input  logic [`FETCH_ADDR_W-1:0] branch_addr_i,
  input  logic                     q_valid_i,
  input  instr_word_u              q_word_i,
  input  logic [`FETCH_ADDR_W-1:0] q_addr_i,
  input  logic                     id_ready_i,
  output logic                     q_pop_o,
  output logic                     if_valid_o,
  output logic [31:0]              if_instr_o,
  output logic [`FETCH_ADDR_W-1:0] if_pc_o,
  output logic                     if_compressed_o,
  output logic                     if_illegal_c_o
);

  // PC of the next instruction, bit 1 picks the parcel in the head word
  logic [`FETCH_ADDR_W-1:0] pc_q;
  logic                     hold_valid_q;
  logic [15:0]              hold_parcel_q;
  logic                     halt_q;

  // Register toward decode
  logic                     out_valid_q;
  logic [31:0]              out_instr_q;
  logic [`FETCH_ADDR_W-1:0] out_pc_q;
  logic                     out_comp_q;
  logic                     out_ill_q;

  logic [`FETCH_ADDR_W-3:0] exp_word;
  logic                     head_ok;
  logic                     head_stale;
  logic [15:0]              cur_parcel;
  instr_word_u              dec_instr;
  logic                     dec_illegal;
  instr_word_u              sel_instr;
  logic                     sel_valid;
  logic                     sel_comp;
  logic                     sel_ill;
  logic                     sel_pop;
  logic                     sel_hold;
  logic                     stall;
  logic                     accept;
  logic                     load;
  logic                     hold_load;

  ////////////////////////////////////////////////////////////
  // Parcel selection
  ////////////////////////////////////////////////////////////

  // A straddling instruction waits for the following word
  assign exp_word   = pc_q[`FETCH_ADDR_W-1:2] + (`FETCH_ADDR_W-2)'(hold_valid_q);
  assign head_ok    = q_valid_i & (q_addr_i[`FETCH_ADDR_W-1:2] == exp_word);
  assign head_stale = q_valid_i & (q_addr_i[`FETCH_ADDR_W-1:2] < exp_word);
  assign cur_parcel = pc_q[1] ? q_word_i.parcel.hi : q_word_i.parcel.lo;

  fetch_c_decoder c_decoder_inst (
    .parcel_i  (cur_parcel),
    .instr_o   (dec_instr),
    .illegal_o (dec_illegal)
  );

  always_comb begin
    sel_instr = q_word_i;
    sel_valid = 1'b0;
    sel_comp  = 1'b0;
    sel_ill   = 1'b0;
    sel_pop   = 1'b0;
    sel_hold  = 1'b0;
    if (head_ok) begin
      if (hold_valid_q) begin
        // Upper half comes from the low parcel of the new word
        sel_instr.parcel.lo = hold_parcel_q;
        sel_instr.parcel.hi = q_word_i.parcel.lo;
        sel_valid           = 1'b1;
      end else if (!is_full_parcel(cur_parcel)) begin
        sel_instr = dec_instr;
        sel_valid = 1'b1;
        sel_comp  = 1'b1;
        sel_ill   = dec_illegal;
        sel_pop   = pc_q[1];
      end else if (!pc_q[1]) begin
        // Aligned 32-bit instruction uses the whole word
        sel_valid = 1'b1;
        sel_pop   = 1'b1;
      end else begin
        // 32-bit start in the high parcel, park it
        sel_hold = 1'b1;
        sel_pop  = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Handshake toward decode
  ////////////////////////////////////////////////////////////

  assign stall     = halt_i | kill_i | pc_set_i;
  assign accept    = if_valid_o & id_ready_i;
  assign load      = sel_valid & (~out_valid_q | accept) & ~stall;
  assign hold_load = sel_hold & ~stall;
  assign q_pop_o   = ~stall & (head_stale | hold_load | (load & sel_pop));

  // Held entry stays hidden while halted
  assign if_valid_o      = out_valid_q & ~halt_q;
  assign if_instr_o      = out_instr_q;
  assign if_pc_o         = out_pc_q;
  assign if_compressed_o = out_comp_q;
  assign if_illegal_c_o  = out_ill_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pc_q         <= `FETCH_BOOT_ADDR;
      hold_valid_q <= 1'b0;
      halt_q       <= 1'b0;
      out_valid_q  <= 1'b0;
    end else begin
      halt_q <= halt_i;
      if (pc_set_i) begin
        pc_q         <= branch_addr_i;
        hold_valid_q <= 1'b0;
      end else if (kill_i) begin
        hold_valid_q <= 1'b0;
      end else if (hold_load) begin
        hold_valid_q <= 1'b1;
      end else if (load) begin
        hold_valid_q <= 1'b0;
        pc_q         <= pc_q + (sel_comp ? `FETCH_ADDR_W'(2) : `FETCH_ADDR_W'(4));
      end
      // Redirect or kill drops whatever was fetched before
      if (kill_i || pc_set_i) begin
        out_valid_q <= 1'b0;
      end else if (load) begin
        out_valid_q <= 1'b1;
      end else if (accept) begin
        out_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (hold_load) begin
      hold_parcel_q <= q_word_i.parcel.hi;
    end
    if (load) begin
      out_instr_q <= sel_instr;
      out_pc_q    <= pc_q;
      out_comp_q  <= sel_comp;
      out_ill_q   <= sel_ill;
    end
  end

endmodule

`default_nettype wire

// ==== fetch_c_decoder.sv ====
`default_nettype none

`include "fetch_consts.svh"

module fetch_c_decoder
  import fetch_pkg::*;
(
  input  logic [15:0] parcel_i,
  output instr_word_u instr_o,
  output logic        illegal_o
);

  logic [4:0]  rd;
  logic [4:0]  rs2;
  logic [11:0] imm_i;
  logic [20:0] imm_j;

  ////////////////////////////////////////////////////////////
  // Field extraction
  ////////////////////////////////////////////////////////////

  assign rd  = parcel_i[11:7];
  assign rs2 = parcel_i[6:2];

  // CI immediate, sign-extended to 12 bits
  assign imm_i = {{6{parcel_i[12]}}, parcel_i[12], parcel_i[6:2]};

  // CJ offset scrambled as [11|4|9:8|10|6|7|3:1|5]
  assign imm_j = {{9{parcel_i[12]}}, parcel_i[12], parcel_i[8], parcel_i[10:9],
                  parcel_i[6], parcel_i[7], parcel_i[2], parcel_i[11],
                  parcel_i[5:3], 1'b0};

  ////////////////////////////////////////////////////////////
  // Expansion
  ////////////////////////////////////////////////////////////

  always_comb begin
    instr_o   = '0;
    illegal_o = 1'b0;
    if (is_full_parcel(parcel_i)) begin
      // Not compressed, nothing to expand
      instr_o.parcel.lo = parcel_i;
    end else begin
      case ({parcel_i[15:13], parcel_i[1:0]})
        // C.ADDI -> addi rd, rd, imm
        {`FETCH_CF3_ADDI, `FETCH_CQ_1}: begin
          instr_o.instr.opcode = `FETCH_OP_IMM;
          instr_o.instr.rd     = rd;
          instr_o.instr.funct3 = `FETCH_F3_ADD;
          instr_o.instr.rs1    = rd;
          {instr_o.instr.funct7, instr_o.instr.rs2} = imm_i;
        end
        // C.LI -> addi rd, x0, imm
        {`FETCH_CF3_LI, `FETCH_CQ_1}: begin
          instr_o.instr.opcode = `FETCH_OP_IMM;
          instr_o.instr.rd     = rd;
          instr_o.instr.funct3 = `FETCH_F3_ADD;
          {instr_o.instr.funct7, instr_o.instr.rs2} = imm_i;
        end
        // C.J -> jal x0, offset
        {`FETCH_CF3_J, `FETCH_CQ_1}: begin
          instr_o = {imm_j[20], imm_j[10:1], imm_j[11], imm_j[19:12], 5'd0, `FETCH_OP_JAL};
        end
        // C.MV / C.ADD, rs2 of x0 would be C.JR / C.JALR / C.EBREAK
        {`FETCH_CF3_MV_ADD, `FETCH_CQ_2}: begin
          if (rs2 == 5'd0) begin
            illegal_o = 1'b1;
          end else begin
            instr_o.instr.opcode = `FETCH_OP_OP;
            instr_o.instr.rd     = rd;
            instr_o.instr.funct3 = `FETCH_F3_ADD;
            instr_o.instr.rs1    = parcel_i[12] ? rd : 5'd0;
            instr_o.instr.rs2    = rs2;
          end
        end
        default: begin
          illegal_o = 1'b1;
        end
      endcase
      // Raw halfword goes on to decode for the trap
      if (illegal_o) begin
        instr_o.parcel.lo = parcel_i;
      end
    end
  end

endmodule

`default_nettype wire

// ==== fetch_consts.svh ====
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// Instruction bus geometry
`define FETCH_ADDR_W          32
`define FETCH_DATA_W          32
`define FETCH_BOOT_ADDR       32'h0000_0000

// Prefetch queue sizing
`define FETCH_QUEUE_DEPTH     2
`define FETCH_MAX_OUTSTANDING 2

// RV32I major opcodes and funct3 used by the expansion
`define FETCH_OP_IMM          7'b0010011
`define FETCH_OP_OP           7'b0110011
`define FETCH_OP_JAL          7'b1101111
`define FETCH_F3_ADD          3'b000

// Compressed quadrants and funct3 values of the supported forms
`define FETCH_CQ_1            2'b01
`define FETCH_CQ_2            2'b10
`define FETCH_CF3_ADDI        3'b000
`define FETCH_CF3_LI          3'b010
`define FETCH_CF3_J           3'b101
`define FETCH_CF3_MV_ADD      3'b100

`endif

// ==== fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

  ////////////////////////////////////////////////////////////
  // Fetched word, seen either as one instruction or two parcels
  ////////////////////////////////////////////////////////////

  typedef union packed {
    // Base 32-bit instruction layout
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } instr;
    // Two halfword parcels, lo sits at the lower address
    struct packed {
      logic [15:0] hi;
      logic [15:0] lo;
    } parcel;
  } instr_word_u;

  ////////////////////////////////////////////////////////////
  // Parcel classification
  ////////////////////////////////////////////////////////////

  // Low bits 11 mark the first parcel of a 32-bit instruction
  function automatic logic is_full_parcel(input logic [15:0] parcel);
    return parcel[1:0] == 2'b11;
  endfunction

endpackage

`default_nettype wire

// ==== fetch_prefetcher.sv ====
`default_nettype none

`include "fetch_consts.svh"

module fetch_prefetcher
  import fetch_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_i,
  input  logic                     halt_i,
  input  logic                     kill_i,
  input  logic                     pc_set_i,
  input  logic [`FETCH_ADDR_W-1:0] branch_addr_i,
  input  logic                     instr_gnt_i,
  input  logic                     instr_rvalid_i,
  input  logic [`FETCH_DATA_W-1:0] instr_rdata_i,
  input  logic                     q_pop_i,
  output logic                     instr_req_o,
  output logic [`FETCH_ADDR_W-1:0] instr_addr_o,
  output logic                     q_valid_o,
  output instr_word_u              q_word_o,
  output logic [`FETCH_ADDR_W-1:0] q_addr_o
);

  localparam int ptr_w = $clog2(`FETCH_QUEUE_DEPTH);
  localparam int cnt_w = $clog2(`FETCH_QUEUE_DEPTH + 1);
  localparam int out_w = $clog2(`FETCH_MAX_OUTSTANDING + 1);

  // Control state
  logic                     boot_q;
  logic                     active_q;
  logic [`FETCH_ADDR_W-1:0] fetch_addr_q;
  logic [`FETCH_ADDR_W-1:0] resp_addr_q;
  logic [out_w-1:0]         out_cnt_q;
  logic [out_w-1:0]         drop_cnt_q;
  logic [cnt_w-1:0]         q_cnt_q;
  logic [ptr_w-1:0]         rd_ptr_q;
  logic [ptr_w-1:0]         wr_ptr_q;

  // Queue storage, word plus the address it came from
  instr_word_u              q_word_mem [`FETCH_QUEUE_DEPTH];
  logic [`FETCH_ADDR_W-1:0] q_addr_mem [`FETCH_QUEUE_DEPTH];

  logic             flush;
  logic [cnt_w:0]   fill;
  logic             room;
  logic             gnt_acc;
  logic             push;
  logic             pop;

  ////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////

  assign flush = pc_set_i | kill_i;

  // Queued words plus requests in flight may not exceed the queue depth
  assign fill = (cnt_w + 1)'(q_cnt_q) + (cnt_w + 1)'(out_cnt_q);
  assign room = (fill < (cnt_w + 1)'(`FETCH_QUEUE_DEPTH))
              & (out_cnt_q < out_w'(`FETCH_MAX_OUTSTANDING));

  assign instr_req_o  = active_q & ~halt_i & ~flush & room;
  assign instr_addr_o = fetch_addr_q;
  assign gnt_acc      = instr_req_o & instr_gnt_i;

  ////////////////////////////////////////////////////////////
  // Response and queue side
  ////////////////////////////////////////////////////////////

  // Stale responses are counted off, not queued
  assign push = instr_rvalid_i & (drop_cnt_q == '0) & ~flush;
  assign pop  = q_pop_i & q_valid_o & ~flush;

  assign q_valid_o = (q_cnt_q != '0);
  assign q_word_o  = q_word_mem[rd_ptr_q];
  assign q_addr_o  = q_addr_mem[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      boot_q       <= 1'b1;
      active_q     <= 1'b0;
      fetch_addr_q <= `FETCH_BOOT_ADDR;
      resp_addr_q  <= `FETCH_BOOT_ADDR;
      out_cnt_q    <= '0;
      drop_cnt_q   <= '0;
      q_cnt_q      <= '0;
      rd_ptr_q     <= '0;
      wr_ptr_q     <= '0;
    end else begin
      boot_q    <= 1'b0;
      out_cnt_q <= out_cnt_q + out_w'(gnt_acc) - out_w'(instr_rvalid_i);
      // Kill parks the stage until the next redirect
      if (kill_i) begin
        active_q <= 1'b0;
      end else if (pc_set_i || boot_q) begin
        active_q <= 1'b1;
      end
      if (flush) begin
        // Everything still in flight after this cycle is stale
        drop_cnt_q <= out_cnt_q - out_w'(instr_rvalid_i);
        q_cnt_q    <= '0;
        rd_ptr_q   <= '0;
        wr_ptr_q   <= '0;
        if (pc_set_i) begin
          fetch_addr_q <= {branch_addr_i[`FETCH_ADDR_W-1:2], 2'b00};
          resp_addr_q  <= {branch_addr_i[`FETCH_ADDR_W-1:2], 2'b00};
        end
      end else begin
        if (instr_rvalid_i && (drop_cnt_q != '0)) begin
          drop_cnt_q <= drop_cnt_q - 1'b1;
        end
        if (gnt_acc) begin
          fetch_addr_q <= fetch_addr_q + `FETCH_ADDR_W'(4);
        end
        // Responses come in order, so the address just counts up
        if (push) begin
          resp_addr_q <= resp_addr_q + `FETCH_ADDR_W'(4);
          wr_ptr_q    <= wr_ptr_q + 1'b1;
        end
        if (pop) begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
        q_cnt_q <= q_cnt_q + cnt_w'(push) - cnt_w'(pop);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      q_word_mem[wr_ptr_q] <= instr_rdata_i;
      q_addr_mem[wr_ptr_q] <= resp_addr_q;
    end
  end

endmodule

`default_nettype wire

// ==== fetch_stage.f ====
+incdir+.
fetch_pkg.sv
fetch_prefetcher.sv
fetch_c_decoder.sv
fetch_aligner.sv
fetch_stage.sv
fetch_stage_properties.sv
tb_fetch_mem.sv
tb_fetch_stage.sv

// ==== fetch_stage.sv ====
`default_nettype none

`include "fetch_consts.svh"

module fetch_stage
  import fetch_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_i,
  input  logic                     halt_i,
  input  logic                     kill_i,
  input  logic                     pc_set_i,
  input  logic [`FETCH_ADDR_W-1:0] branch_addr_i,
  input  logic                     instr_gnt_i,
  input  logic                     instr_rvalid_i,
  input  logic [`FETCH_DATA_W-1:0] instr_rdata_i,
  input  logic                     id_ready_i,
  output logic                     instr_req_o,
  output logic [`FETCH_ADDR_W-1:0] instr_addr_o,
  output logic                     if_valid_o,
  output logic [31:0]              if_instr_o,
  output logic [`FETCH_ADDR_W-1:0] if_pc_o,
  output logic                     if_compressed_o,
  output logic                     if_illegal_c_o
);

  // Queue head handed from prefetcher to aligner
  logic                     q_valid;
  instr_word_u              q_word;
  logic [`FETCH_ADDR_W-1:0] q_addr;
  logic                     q_pop;

  ////////////////////////////////////////////////////////////
  // Bus side, fetches words and queues them
  ////////////////////////////////////////////////////////////

  fetch_prefetcher prefetcher_inst (
    .clk            (clk),
    .rst_i          (rst_i),
    .halt_i         (halt_i),
    .kill_i         (kill_i),
    .pc_set_i       (pc_set_i),
    .branch_addr_i  (branch_addr_i),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .q_pop_i        (q_pop),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .q_valid_o      (q_valid),
    .q_word_o       (q_word),
    .q_addr_o       (q_addr)
  );

  ////////////////////////////////////////////////////////////
  // Decode side, splits words into instructions
  ////////////////////////////////////////////////////////////

  fetch_aligner aligner_inst (
    .clk             (clk),
    .rst_i           (rst_i),
    .halt_i          (halt_i),
    .kill_i          (kill_i),
    .pc_set_i        (pc_set_i),
    .branch_addr_i   (branch_addr_i),
    .q_valid_i       (q_valid),
    .q_word_i        (q_word),
    .q_addr_i        (q_addr),
    .id_ready_i      (id_ready_i),
    .q_pop_o         (q_pop),
    .if_valid_o      (if_valid_o),
    .if_instr_o      (if_instr_o),
    .if_pc_o         (if_pc_o),
    .if_compressed_o (if_compressed_o),
    .if_illegal_c_o  (if_illegal_c_o)
  );

endmodule

`default_nettype wire

// ==== fetch_stage_properties.sv ====
`default_nettype none

module fetch_stage_properties (
  input logic        clk,
  input logic        rst_i,
  input logic        halt_i,
  input logic        kill_i,
  input logic        pc_set_i,
  input logic        id_ready_i,
  input logic        instr_req_o,
  input logic [31:0] instr_addr_o,
  input logic        if_valid_o,
  input logic [31:0] if_instr_o,
  input logic [31:0] if_pc_o,
  input logic        if_compressed_o,
  input logic        if_illegal_c_o
);

  int fail_cnt = 0;

  ////////////////////////////////////////////////////////////
  // Bus side
  ////////////////////////////////////////////////////////////

  a_addr_aligned: assert property (@(posedge clk) disable iff (rst_i)
    instr_addr_o[1:0] == 2'b00)
    else begin
      fail_cnt++;
      $error("instr_addr_o not word aligned");
    end

  ////////////////////////////////////////////////////////////
  // Controller levels
  ////////////////////////////////////////////////////////////

  a_halt_blocks: assert property (@(posedge clk) disable iff (rst_i)
    halt_i |=> !if_valid_o)
    else begin
      fail_cnt++;
      $error("if_valid_o high one cycle after halt_i");
    end

  a_kill_blocks: assert property (@(posedge clk) disable iff (rst_i)
    kill_i |=> (!if_valid_o && !instr_req_o))
    else begin
      fail_cnt++;
      $error("if_valid_o or instr_req_o high one cycle after kill_i");
    end

  // Stalled decode side keeps the whole entry
  a_stall_stable: assert property (@(posedge clk) disable iff (rst_i)
    (if_valid_o && !id_ready_i && !halt_i && !kill_i && !pc_set_i) |=>
      (if_valid_o && $stable(if_instr_o) && $stable(if_pc_o)
       && $stable(if_compressed_o) && $stable(if_illegal_c_o)))
    else begin
      fail_cnt++;
      $error("decode side outputs changed while stalled");
    end

endmodule

bind fetch_stage fetch_stage_properties props_inst (.*);

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the fetch stage testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_fetch_stage -f fetch_stage.f -o Vtb_fetch_stage
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_fetch_stage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation run returned status $status"
fi

if grep -q "Simulation completed successfully" "$LOG"; then
  exit 0
fi
exit 1

// ==== tb_fetch_mem.sv ====
`default_nettype none

module tb_fetch_mem (
  input  logic        clk,
  input  logic        rst_i,
  input  logic        req_i,
  input  logic [31:0] addr_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o
);

  // Program image, 256 words, indexed by address bits 9:2
  logic [31:0] mem [256];
  // Granted addresses still waiting for their response
  logic [31:0] pend [$];
  int          gnt_wait;
  int          resp_wait;

  initial begin
    gnt_o     = 1'b0;
    rvalid_o  = 1'b0;
    rdata_o   = '0;
    gnt_wait  = 0;
    resp_wait = 0;
    // Default fill, an I-type word carrying its own index
    for (int i = 0; i < 256; i++) begin
      mem[i] = {i[24:0], 7'b0010011};
    end
  end

  always @(posedge clk) begin
    if (rst_i) begin
      gnt_o     <= 1'b0;
      rvalid_o  <= 1'b0;
      gnt_wait  = 0;
      resp_wait = 0;
      pend.delete();
    end else begin
      // Request accepted on this edge
      if (req_i && gnt_o) begin
        pend.push_back(addr_i);
        gnt_wait = int'($urandom % 4);
      end
      gnt_o <= (gnt_wait == 0);
      if (gnt_wait != 0) begin
        gnt_wait--;
      end
      // In-order responses, 0 to 3 cycles apart
      rvalid_o <= 1'b0;
      if (pend.size() > 0) begin
        if (resp_wait == 0) begin
          rvalid_o  <= 1'b1;
          rdata_o   <= mem[pend[0][9:2]];
          void'(pend.pop_front());
          resp_wait = int'($urandom % 4);
        end else begin
          resp_wait--;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_fetch_stage.sv ====
`default_nettype none

`include "fetch_consts.svh"

module tb_fetch_stage;

  logic        clk;
  logic        rst_i;
  logic        halt_i;
  logic        kill_i;
  logic        pc_set_i;
  logic [31:0] branch_addr_i;
  logic        instr_gnt_i;
  logic        instr_rvalid_i;
  logic [31:0] instr_rdata_i;
  logic        id_ready_i;
  logic        instr_req_o;
  logic [31:0] instr_addr_o;
  logic        if_valid_o;
  logic [31:0] if_instr_o;
  logic [31:0] if_pc_o;
  logic        if_compressed_o;
  logic        if_illegal_c_o;

  int          errors;
  int          xfer_count;
  int          test_fails;
  int          test_errs;
  logic        rand_ready;
  logic [31:0] exp_pc;
  logic        killed;
  logic        halt_prev;

  // Mixed program at 0x100 with every supported form, odd 32-bit starts and illegal encodings
  logic [15:0] mixed [16] = '{16'h028D, 16'h0533, 16'h00A5, 16'h557D,
                              16'hBFFD, 16'h8426, 16'h9426, 16'h8082,
                              16'h0000, 16'h4398, 16'h0093, 16'h02A0,
                              16'h1FFD, 16'h8133, 16'h4020, 16'hA011};

  fetch_stage fetch_stage_inst (.*);

  tb_fetch_mem mem_inst (
    .clk      (clk),
    .rst_i    (rst_i),
    .req_i    (instr_req_o),
    .addr_i   (instr_addr_o),
    .gnt_o    (instr_gnt_i),
    .rvalid_o (instr_rvalid_i),
    .rdata_o  (instr_rdata_i)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Reference model and checking
  ////////////////////////////////////////////////////////////

  function automatic logic [15:0] half_at(input logic [31:0] a);
    logic [31:0] w;
    w = mem_inst.mem[a[9:2]];
    return a[1] ? w[31:16] : w[15:0];
  endfunction

  // Next instruction from the image at pc expanded per the RVC rules
  function automatic void ref_fetch(input logic [31:0] pc, output logic [31:0] instr,
                                    output logic comp, output logic ill,
                                    output logic [31:0] next_pc);
    logic [15:0] p;
    logic [11:0] imm;
    logic [20:0] off;
    p       = half_at(pc);
    imm     = {{7{p[12]}}, p[6:2]};
    off     = {21{p[12]}};
    off[10] = p[8];
    off[9:8] = p[10:9];
    off[7]  = p[6];
    off[6]  = p[7];
    off[5]  = p[2];
    off[4]  = p[11];
    off[3:1] = p[5:3];
    off[0]  = 1'b0;
    comp    = 1'b1;
    ill     = 1'b0;
    next_pc = pc + 32'd2;
    instr   = {16'h0000, p};
    if (p[1:0] == 2'b11) begin
      instr   = {half_at(pc + 32'd2), p};
      comp    = 1'b0;
      next_pc = pc + 32'd4;
    end else if (p[1:0] == `FETCH_CQ_1 && p[15:13] == `FETCH_CF3_ADDI) begin
      instr = {imm, p[11:7], `FETCH_F3_ADD, p[11:7], `FETCH_OP_IMM};
    end else if (p[1:0] == `FETCH_CQ_1 && p[15:13] == `FETCH_CF3_LI) begin
      instr = {imm, 5'd0, `FETCH_F3_ADD, p[11:7], `FETCH_OP_IMM};
    end else if (p[1:0] == `FETCH_CQ_1 && p[15:13] == `FETCH_CF3_J) begin
      instr = {off[20], off[10:1], off[11], off[19:12], 5'd0, `FETCH_OP_JAL};
    end else if (p[1:0] == `FETCH_CQ_2 && p[15:13] == `FETCH_CF3_MV_ADD && p[6:2] != 0) begin
      instr = {7'd0, p[6:2], (p[12] ? p[11:7] : 5'd0), `FETCH_F3_ADD, p[11:7], `FETCH_OP_OP};
    end else begin
      ill = 1'b1;
    end
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Compares each accepted transfer and follows redirects, kill and halt
  always @(posedge clk) begin
    logic [31:0] e_instr;
    logic [31:0] e_next;
    logic        e_comp;
    logic        e_ill;
    if (rst_i) begin
      exp_pc    = `FETCH_BOOT_ADDR;
      killed    = 1'b0;
      halt_prev = 1'b0;
    end else begin
      if (if_valid_o && id_ready_i) begin
        if (killed || halt_prev) begin
          errors++;
          $display("ERROR t=%0t transfer of pc %h while halted or killed", $time, if_pc_o);
        end else begin
          ref_fetch(exp_pc, e_instr, e_comp, e_ill, e_next);
          check("if_pc_o", if_pc_o, exp_pc);
          check("if_instr_o", if_instr_o, e_instr);
          check("if_compressed_o", {31'd0, if_compressed_o}, {31'd0, e_comp});
          check("if_illegal_c_o", {31'd0, if_illegal_c_o}, {31'd0, e_ill});
          exp_pc = e_next;
        end
        xfer_count++;
      end
      halt_prev = halt_i;
      if (kill_i) begin
        killed = 1'b1;
      end
      if (pc_set_i) begin
        exp_pc = branch_addr_i;
        killed = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    id_ready_i <= rand_ready ? 1'($urandom % 2) : 1'b1;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  task automatic redirect(input logic [31:0] target);
    @(posedge clk);
    pc_set_i      <= 1'b1;
    branch_addr_i <= target;
    @(posedge clk);
    pc_set_i <= 1'b0;
  endtask

  task automatic wait_xfers(input int n);
    int target;
    target = xfer_count + n;
    // Wakes in the time step of the transfer that reaches the count
    while (xfer_count < target) begin
      @(xfer_count);
    end
  endtask

  task automatic report_test(input int num, input string name);
    if (errors != test_errs) begin
      test_fails++;
    end
    $display("test %0d %s: %s", num, name, (errors == test_errs) ? "PASS" : "FAIL");
    test_errs = errors;
  endtask

  initial begin
    #(6 * 400 * 20);
    $display("ERROR watchdog expired, the DUT stopped delivering instructions");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    void'($urandom(32'h699c));
    errors        = 0;
    xfer_count    = 0;
    test_fails    = 0;
    test_errs     = 0;
    rand_ready    = 1'b0;
    rst_i         = 1'b1;
    halt_i        = 1'b0;
    kill_i        = 1'b0;
    pc_set_i      = 1'b0;
    branch_addr_i = '0;
    id_ready_i    = 1'b1;
    @(posedge clk);
    for (int i = 0; i < 8; i++) begin
      mem_inst.mem[64 + i] = {mixed[2 * i + 1], mixed[2 * i]};
    end
    repeat (3) @(posedge clk);
    rst_i <= 1'b0;

    wait_xfers(16);
    report_test(1, "straight line 32-bit");
    redirect(32'h100);
    wait_xfers(17);
    report_test(2, "mixed compressed");
    redirect(32'h102);
    wait_xfers(12);
    report_test(3, "redirect odd halfword");
    rand_ready <= 1'b1;
    redirect(32'h100);
    wait_xfers(20);
    rand_ready <= 1'b0;
    report_test(4, "random back-pressure");
    redirect(32'h100);
    wait_xfers(4);
    halt_i <= 1'b1;
    repeat (6) @(posedge clk);
    halt_i <= 1'b0;
    wait_xfers(14);
    report_test(5, "halt");
    wait_xfers(3);
    kill_i <= 1'b1;
    repeat (3) @(posedge clk);
    kill_i <= 1'b0;
    repeat (10) @(posedge clk);
    redirect(32'h106);
    wait_xfers(10);
    report_test(6, "kill and restart");

    errors += fetch_stage_inst.props_inst.fail_cnt;
    $display("Summary: 6 tests, %0d failed, %0d errors", test_fails, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
